//--- list.f
src/poly_pkg.sv
src/stp_pkg.sv
src/ram_if.sv
src/token_fifo.sv
src/coef_ram.sv
src/mem_ctrl.sv
src/degree_table.sv
src/stp_fsm.sv
src/poly_store_top.sv
testbench/poly_checker.sv
testbench/tb_poly_store.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module tb_poly_store -Mdir obj_dir

output=$(./obj_dir/Vtb_poly_store)
echo "$output"

if echo "$output" | grep -q "^Simulation finished: PASS$"; then
   exit 0
fi
exit 1

//--- src/coef_ram.sv
`timescale 1ns/1ps

module coef_ram
   import poly_pkg::*;
#(
   parameter int DEPTH = BUF_DEPTH
)
(
   input  logic clk,
   ram_if.mem   bus
);

   // Word array
   coef_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      // Plain write
      if (bus.wr_en)
         mem[bus.wr_addr] <= bus.wr_data;
      // Registered read with q valid the cycle after rd_en
      if (bus.rd_en)
         bus.q <= mem[bus.rd_addr];
   end

   // Store depth is not a power of two
   a_wr_in_range: assert property (@(posedge clk)
      bus.wr_en |-> bus.wr_addr < DEPTH);

endmodule

//--- src/degree_table.sv
`timescale 1ns/1ps

module degree_table
   import poly_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wr_en,
   input  logic [SLOT_W-1:0] wr_slot,
   input  logic [SLOT_W-1:0] rd_slot,
   input  logic [DEG_W-1:0]  wr_degree,
   output logic              valid
);

   // Degree per slot
   logic [DEG_W-1:0]   degrees [N_SLOTS];
   // Occupancy with one bit per slot
   logic [N_SLOTS-1:0] valid_bits;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         degrees[wr_slot] <= wr_degree;
   end

   // All slots empty after reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid_bits <= '0;
      else if (wr_en)
         valid_bits[wr_slot] <= 1'b1;
   end

   assign valid = valid_bits[rd_slot];

   // Only legal degrees ever get recorded
   a_legal_degree: assert property (@(posedge clk) disable iff (!rst_n)
      valid |-> degrees[rd_slot] <= MAX_DEGREE);

endmodule

//--- src/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl
   import poly_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [BUF_AW:0]   fifo_count,
   input  coef_t             fifo_dout,
   output logic              fifo_rd_en,
   ram_if.writer             ram,
   output logic [BUF_AW-1:0] load_ptr
);

   // Drain one word per cycle while the FIFO holds anything
   assign fifo_rd_en = (fifo_count != '0);

   // FIFO head goes straight into the RAM in the same cycle
   assign ram.wr_en   = fifo_rd_en;
   assign ram.wr_addr = load_ptr;
   assign ram.wr_data = fifo_dout;

   // Load pointer
   // Next free RAM word wrapping modulo BUF_DEPTH
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         load_ptr <= '0;
      else if (fifo_rd_en)
         load_ptr <= load_ptr + 1'b1;
   end

endmodule

//--- src/poly_pkg.sv
package poly_pkg;

   // Coefficient and token widths
   localparam int WORD_W = 16;
   localparam int TOKEN_W = 32;

   // Data FIFO and data RAM depth
   localparam int BUF_DEPTH = 64;
   localparam int BUF_AW = $clog2(BUF_DEPTH);

   // Slot geometry of the coefficient store
   localparam int N_SLOTS = 8;
   localparam int SLOT_W = $clog2(N_SLOTS);
   localparam int MAX_DEGREE = 10;
   // degree 10 means eleven coefficients
   localparam int SLOT_WORDS = MAX_DEGREE + 1;
   localparam int STORE_DEPTH = N_SLOTS * SLOT_WORDS;
   localparam int STORE_AW = $clog2(STORE_DEPTH);

   // Wide enough for illegal degrees too
   localparam int DEG_W = 5;

   typedef logic [WORD_W-1:0] coef_t;
   typedef logic [TOKEN_W-1:0] token_t;

endpackage

//--- src/poly_store_top.sv
`timescale 1ns/1ps

module poly_store_top
   import poly_pkg::*;
   import stp_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        data_wr_en,
   input  logic [15:0] data_in,
   output logic [6:0]  data_free,
   input  logic        start_stp,
   input  logic [2:0]  slot,
   input  logic [4:0]  degree,
   output logic        done_stp,
   input  logic        res_rd_en,
   output logic [31:0] res_out,
   output logic [6:0]  res_count,
   input  logic        stat_rd_en,
   output logic [31:0] stat_out,
   output logic [6:0]  stat_count
);

   logic              fifo_rd_en;
   coef_t             fifo_dout;
   logic [BUF_AW:0]   data_count;
   logic [BUF_AW-1:0] load_ptr;
   logic              slot_valid;
   logic              deg_wr_en;
   logic              res_push;
   logic              stat_push;
   token_t            res_token;
   token_t            stat_token;
   logic [BUF_AW:0]   res_free;
   logic [BUF_AW:0]   stat_free;
   logic              stat_full;
   logic [SLOT_W-1:0] tok_slot;
   logic [DEG_W-1:0]  tok_degree;

   ram_if #(.AW(BUF_AW))   data_bus ();
   ram_if #(.AW(STORE_AW)) store_bus ();

   // Store is write only in this unit
   assign store_bus.rd_en   = 1'b0;
   assign store_bus.rd_addr = '0;

   assign stat_full = (stat_free == '0);
   // Latched slot and degree taken from the status token fields
   assign tok_slot   = stat_token[STAT_SLOT_LSB +: SLOT_W];
   assign tok_degree = stat_token[STAT_DEG_LSB +: DEG_W];

   token_fifo #(.payload_t(coef_t)) u_data_fifo (
      .clk(clk), .rst_n(rst_n), .wr_en(data_wr_en), .rd_en(fifo_rd_en),
      .din(data_in), .dout(fifo_dout), .count(data_count), .free(data_free));

   mem_ctrl u_mem_ctrl (
      .clk(clk), .rst_n(rst_n), .fifo_count(data_count), .fifo_dout(fifo_dout),
      .fifo_rd_en(fifo_rd_en), .ram(data_bus.writer), .load_ptr(load_ptr));

   coef_ram #(.DEPTH(BUF_DEPTH)) u_data_ram (.clk(clk), .bus(data_bus.mem));
   coef_ram #(.DEPTH(STORE_DEPTH)) u_store_ram (.clk(clk), .bus(store_bus.mem));

   degree_table u_degree_table (
      .clk(clk), .rst_n(rst_n), .wr_en(deg_wr_en), .wr_slot(tok_slot),
      .rd_slot(tok_slot), .wr_degree(tok_degree), .valid(slot_valid));

   stp_fsm u_stp_fsm (
      .clk(clk), .rst_n(rst_n), .start_stp(start_stp), .slot(slot), .degree(degree),
      .load_ptr(load_ptr), .data(data_bus.reader), .store(store_bus.writer),
      .slot_valid(slot_valid), .deg_wr_en(deg_wr_en), .res_free(res_free),
      .stat_full(stat_full), .res_push(res_push), .stat_push(stat_push),
      .res_token(res_token), .stat_token(stat_token), .done_stp(done_stp));

   // Output token FIFOs
   token_fifo #(.payload_t(token_t)) u_res_fifo (
      .clk(clk), .rst_n(rst_n), .wr_en(res_push), .rd_en(res_rd_en),
      .din(res_token), .dout(res_out), .count(res_count), .free(res_free));

   token_fifo #(.payload_t(token_t)) u_stat_fifo (
      .clk(clk), .rst_n(rst_n), .wr_en(stat_push), .rd_en(stat_rd_en),
      .din(stat_token), .dout(stat_out), .count(stat_count), .free(stat_free));

endmodule

//--- src/ram_if.sv
`timescale 1ns/1ps

interface ram_if
   import poly_pkg::*;
#(
   parameter int AW = BUF_AW
);

   // Write port
   logic          wr_en;
   logic [AW-1:0] wr_addr;
   coef_t         wr_data;

   // Read port with q one cycle behind rd_en
   logic          rd_en;
   logic [AW-1:0] rd_addr;
   coef_t         q;

   modport writer (output wr_en, wr_addr, wr_data);
   modport reader (output rd_en, rd_addr, input q);
   // RAM side
   modport mem (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output q);

endinterface

//--- src/stp_fsm.sv
`timescale 1ns/1ps

module stp_fsm
   import poly_pkg::*;
   import stp_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start_stp,
   input  logic [SLOT_W-1:0] slot,
   input  logic [DEG_W-1:0]  degree,
   input  logic [BUF_AW-1:0] load_ptr,
   ram_if.reader             data,
   ram_if.writer             store,
   input  logic              slot_valid,
   output logic              deg_wr_en,
   input  logic [BUF_AW:0]   res_free,
   input  logic              stat_full,
   output logic              res_push,
   output logic              stat_push,
   output token_t            res_token,
   output token_t            stat_token,
   output logic              done_stp
);

   stp_state_t           state;
   stp_state_t           next_state;
   // Command latched at start
   logic [SLOT_W-1:0]    slot_r;
   logic [DEG_W-1:0]     deg_r;
   stat_code_t           code_r;
   // Coefficient index within the command
   logic [RES_IDX_W-1:0] idx_r;
   // First unread word of the data RAM
   logic [BUF_AW-1:0]    rd_ptr;
   logic [BUF_AW:0]      avail;
   logic [BUF_AW:0]      need;
   logic                 bad_degree;
   logic                 underflow;
   logic [STORE_AW-1:0]  base_addr;

   // Unread words modulo depth
   assign avail = {1'b0, load_ptr - rd_ptr};
   assign need = (BUF_AW+1)'(deg_r) + (BUF_AW+1)'(1);
   assign bad_degree = deg_r > DEG_W'(MAX_DEGREE);
   assign underflow = avail < need;
   assign base_addr = STORE_AW'(slot_r) * STORE_AW'(SLOT_WORDS);

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
            if (start_stp)
               next_state = CHECK;
         CHECK:
            // Waits for room in the output FIFOs
            if (!stat_full)
            begin
               if (bad_degree || underflow)
                  next_state = ERROR;
               else if (res_free >= need)
                  next_state = READ;
            end
         READ:
            next_state = WRITE;
         WRITE:
            if (idx_r == deg_r[RES_IDX_W-1:0])
               next_state = REPORT;
            else
               next_state = READ;
         default:
            next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= IDLE;
         idx_r  <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == IDLE)
            idx_r <= '0;
         else if (state == WRITE)
            idx_r <= idx_r + 1'b1;
         // Words consumed only on success
         if (state == REPORT)
            rd_ptr <= rd_ptr + need[BUF_AW-1:0];
      end
   end

   // Command fields and status code
   always_ff @(posedge clk)
   begin
      if (state == IDLE && start_stp)
      begin
         slot_r <= slot;
         deg_r  <= degree;
      end
      if (state == CHECK)
      begin
         if (bad_degree)
            code_r <= STAT_BAD_DEGREE;
         else if (underflow)
            code_r <= STAT_UNDERFLOW;
         else if (slot_valid)
            code_r <= STAT_OK_REPLACED;
         else
            code_r <= STAT_OK_NEW;
      end
   end

   // READ fetches and WRITE stores what came back
   assign data.rd_en   = (state == READ);
   assign data.rd_addr = rd_ptr + BUF_AW'(idx_r);
   assign store.wr_en   = (state == WRITE);
   assign store.wr_addr = base_addr + STORE_AW'(idx_r);
   assign store.wr_data = data.q;

   assign res_push  = (state == WRITE);
   assign deg_wr_en = (state == REPORT);
   assign stat_push = (state == REPORT) || (state == ERROR);
   assign done_stp  = stat_push;

   always_comb
   begin
      res_token = '0;
      res_token[RES_SLOT_LSB +: SLOT_W] = slot_r;
      res_token[RES_IDX_LSB +: RES_IDX_W] = idx_r;
      res_token[RES_COEF_LSB +: WORD_W] = data.q;
   end

   // Slot field also addresses the degree table
   always_comb
   begin
      stat_token = '0;
      stat_token[STAT_CODE_LSB +: $bits(stat_code_t)] = code_r;
      stat_token[STAT_SLOT_LSB +: SLOT_W] = slot_r;
      stat_token[STAT_DEG_LSB +: DEG_W] = deg_r;
   end

   // Stays inside the eleven words of the latched slot
   a_slot_region: assert property (@(posedge clk) disable iff (!rst_n)
      store.wr_en |-> (store.wr_addr >= base_addr)
                      && (store.wr_addr < base_addr + STORE_AW'(SLOT_WORDS)));

endmodule

//--- src/stp_pkg.sv
package stp_pkg;

   // Store FSM states
   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      CHECK  = 3'd1,
      READ   = 3'd2,
      WRITE  = 3'd3,
      REPORT = 3'd4,
      ERROR  = 3'd5
   } stp_state_t;

   // Status codes with the top bits set on errors
   typedef enum logic [7:0] {
      STAT_OK_NEW      = 8'h00,
      STAT_OK_REPLACED = 8'h01,
      STAT_BAD_DEGREE  = 8'hE0,
      STAT_UNDERFLOW   = 8'hE1
   } stat_code_t;

   // Result token fields
   localparam int RES_SLOT_LSB = 29;
   localparam int RES_IDX_LSB = 25;
   localparam int RES_IDX_W = 4;
   localparam int RES_COEF_LSB = 0;

   // Status token fields
   localparam int STAT_CODE_LSB = 24;
   localparam int STAT_SLOT_LSB = 8;
   localparam int STAT_DEG_LSB = 0;

endpackage

//--- src/token_fifo.sv
`timescale 1ns/1ps

module token_fifo
   import poly_pkg::*;
#(
   parameter type payload_t = coef_t
)
(
   input  logic            clk,
   input  logic            rst_n,
   input  logic            wr_en,
   input  logic            rd_en,
   input  payload_t        din,
   output payload_t        dout,
   output logic [BUF_AW:0] count,
   output logic [BUF_AW:0] free
);

   // Circular buffer storage
   payload_t          mem [BUF_DEPTH];
   logic [BUF_AW-1:0] wr_ptr;
   logic [BUF_AW-1:0] rd_ptr;
   logic              do_wr;
   logic              do_rd;

   // Writes to a full FIFO and reads of an empty one do nothing
   assign do_wr = wr_en && (count != (BUF_AW+1)'(BUF_DEPTH));
   assign do_rd = rd_en && (count != '0);

   // Head visible without waiting for the edge
   assign dout = mem[rd_ptr];
   assign free = (BUF_AW+1)'(BUF_DEPTH) - count;

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

   // Pointers and population
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves count alone
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

   // Producer must respect the free count
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> count != (BUF_AW+1)'(BUF_DEPTH));
   // Consumer must respect the population
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> count != '0);

endmodule

//--- testbench/poly_checker.sv
`timescale 1ns/1ps

module poly_checker
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        hold_res,
   input  logic [31:0] res_out,
   input  logic [6:0]  res_count,
   input  logic [31:0] stat_out,
   input  logic [6:0]  stat_count,
   output logic        res_rd_en,
   output logic        stat_rd_en
);

   // Tokens still owed by the DUT in arrival order
   logic [31:0] res_q[$];
   logic [31:0] stat_q[$];
   // Hold request retimed to the rising edge
   logic        hold_q;
   int          error_count;
   int          check_count;
   int          test_errors_start;
   int          test_num;
   string       test_name;

   initial
   begin
      res_rd_en = 1'b0;
      stat_rd_en = 1'b0;
      hold_q = 1'b0;
      error_count = 0;
      check_count = 0;
      test_errors_start = 0;
      test_num = 0;
   end

   always @(posedge clk)
      hold_q <= hold_res;

   task automatic flag_mismatch(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      error_count++;
   endtask

   task automatic flag_problem(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      error_count++;
   endtask

   task automatic compare_token(input string kind, input logic [31:0] got,
                                input logic [31:0] exp);
      check_count++;
      if (got !== exp)
         flag_mismatch($sformatf("%s token %h, expected %h", kind, got, exp));
   endtask

   task automatic expect_result(input logic [31:0] tok);
      res_q.push_back(tok);
   endtask

   task automatic expect_status(input logic [31:0] tok);
      stat_q.push_back(tok);
   endtask

   // Pop on the falling edge where head and counts are settled
   always @(negedge clk)
   begin
      res_rd_en = 1'b0;
      stat_rd_en = 1'b0;
      if (rst_n && res_count != 7'd0 && !hold_q)
      begin
         res_rd_en = 1'b1;
         if (res_q.size() == 0)
            flag_problem($sformatf("result token %h arrived with none expected", res_out));
         else
            compare_token("result", res_out, res_q.pop_front());
      end
      if (rst_n && stat_count != 7'd0)
      begin
         stat_rd_en = 1'b1;
         if (stat_q.size() == 0)
            flag_problem($sformatf("status token %h arrived with none expected", stat_out));
         else
            compare_token("status", stat_out, stat_q.pop_front());
      end
   end

   task automatic begin_test(input int num, input string name);
      test_num = num;
      test_name = name;
      test_errors_start = error_count;
   endtask

   // Wait for owed tokens and then report the test
   task automatic end_test();
      int waited;
      waited = 0;
      while ((res_q.size() != 0 || stat_q.size() != 0) && waited < 300)
      begin
         @(negedge clk);
         waited++;
      end
      if (res_q.size() != 0 || stat_q.size() != 0)
         flag_problem($sformatf("%0d result and %0d status tokens never came out",
                                res_q.size(), stat_q.size()));
      // A few idle cycles catch stray extra tokens
      repeat (3) @(negedge clk);
      if (error_count == test_errors_start)
         $display("Test %0d (%s): passed", test_num, test_name);
      else
         $display("Test %0d (%s): failed with %0d errors", test_num, test_name,
                  error_count - test_errors_start);
   endtask

   task automatic report_totals();
      $display("Totals: %0d token checks, %0d errors", check_count, error_count);
   endtask

endmodule

//--- testbench/tb_poly_store.sv
`timescale 1ns/1ps

module tb_poly_store
   import poly_pkg::*;
   import stp_pkg::*;
();

   localparam int CLK_PERIOD = 8;
   localparam int N_TESTS = 6;
   localparam int TIMEOUT_CYCLES = 200 * N_TESTS + 500;

   logic        clk;
   logic        rst_n;
   logic        data_wr_en;
   logic [15:0] data_in;
   logic [6:0]  data_free;
   logic        start_stp;
   logic [2:0]  slot;
   logic [4:0]  degree;
   logic        done_stp;
   logic        res_rd_en;
   logic [31:0] res_out;
   logic [6:0]  res_count;
   logic        stat_rd_en;
   logic [31:0] stat_out;
   logic [6:0]  stat_count;
   logic        hold_res;

   // Model of unconsumed loaded words and slot occupancy
   logic [15:0] unread_q[$];
   logic [7:0]  occupied;
   int          last_latency;

   poly_store_top i_dut (
      .clk(clk), .rst_n(rst_n), .data_wr_en(data_wr_en), .data_in(data_in),
      .data_free(data_free), .start_stp(start_stp), .slot(slot), .degree(degree),
      .done_stp(done_stp), .res_rd_en(res_rd_en), .res_out(res_out),
      .res_count(res_count), .stat_rd_en(stat_rd_en), .stat_out(stat_out),
      .stat_count(stat_count));

   poly_checker u_chk (
      .clk(clk), .rst_n(rst_n), .hold_res(hold_res), .res_out(res_out),
      .res_count(res_count), .stat_out(stat_out), .stat_count(stat_count),
      .res_rd_en(res_rd_en), .stat_rd_en(stat_rd_en));

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Status token of code, zero byte, slot and degree
   function automatic logic [31:0] expected_status(input logic [2:0] s, input logic [4:0] d,
                                                   input int unread, input logic used);
      stat_code_t code;
      if (d > 5'(MAX_DEGREE))
         code = STAT_BAD_DEGREE;
      else if (int'(d) + 1 > unread)
         code = STAT_UNDERFLOW;
      else if (used)
         code = STAT_OK_REPLACED;
      else
         code = STAT_OK_NEW;
      return {code, 8'h00, 5'b0, s, 3'b0, d};
   endfunction

   // Result token of slot, index, zero gap and coefficient
   function automatic logic [31:0] expected_result(input logic [2:0] s, input int idx,
                                                   input logic [15:0] coef);
      return {s, idx[3:0], 9'b0, coef};
   endfunction

   task automatic load_words(input int n);
      int waited;
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         data_wr_en = 1'b1;
         data_in = 16'($urandom);
         unread_q.push_back(data_in);
      end
      @(negedge clk);
      data_wr_en = 1'b0;
      waited = 0;
      // Empty data FIFO means every word reached the data RAM
      while (data_free != 7'd64 && waited < 100)
      begin
         @(negedge clk);
         waited++;
      end
      if (data_free != 7'd64)
         u_chk.flag_problem($sformatf("data FIFO still holds %0d words after loading",
                                      64 - int'(data_free)));
   endtask

   task automatic run_store(input logic [2:0] s, input logic [4:0] d, input bit check_lat);
      logic [31:0] stat_exp;
      logic        ok;
      int          expect_cycles;
      int          cycles;
      stat_exp = expected_status(s, d, unread_q.size(), occupied[s]);
      ok = (stat_exp[31:24] == STAT_OK_NEW) || (stat_exp[31:24] == STAT_OK_REPLACED);
      expect_cycles = 3;
      if (ok)
      begin
         for (int i = 0; i <= int'(d); i++)
            u_chk.expect_result(expected_result(s, i, unread_q[i]));
         for (int i = 0; i <= int'(d); i++)
            unread_q.delete(0);
         occupied[s] = 1'b1;
         expect_cycles = 2 * (int'(d) + 1) + 3;
      end
      u_chk.expect_status(stat_exp);
      // Cycle of the start strobe counts as the first
      @(negedge clk);
      start_stp = 1'b1;
      slot = s;
      degree = d;
      cycles = 1;
      do
      begin
         @(negedge clk);
         start_stp = 1'b0;
         cycles++;
      end
      while (!done_stp && cycles < 2000);
      last_latency = cycles;
      if (!done_stp)
         u_chk.flag_problem($sformatf("store to slot %0d never raised done_stp", s));
      else if (check_lat && cycles != expect_cycles)
         u_chk.flag_mismatch($sformatf("slot %0d degree %0d took %0d cycles, expected %0d",
                                       s, d, cycles, expect_cycles));
   endtask

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      data_wr_en = 1'b0;
      data_in = '0;
      start_stp = 1'b0;
      slot = '0;
      degree = '0;
      hold_res = 1'b0;
      occupied = '0;
      last_latency = 0;
      void'($urandom(69681));
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      u_chk.begin_test(1, "store into an empty slot");
      load_words(6);
      run_store(3'd2, 5'd3, 1'b1);
      u_chk.end_test();

      u_chk.begin_test(2, "replace an occupied slot");
      run_store(3'd2, 5'd1, 1'b1);
      u_chk.end_test();

      // Rejected request must leave its words for the next one
      u_chk.begin_test(3, "illegal degree");
      load_words(4);
      run_store(3'd5, 5'd12, 1'b1);
      run_store(3'd5, 5'd3, 1'b1);
      u_chk.end_test();

      u_chk.begin_test(4, "too few unread words");
      load_words(3);
      run_store(3'd1, 5'd3, 1'b1);
      load_words(2);
      run_store(3'd1, 5'd3, 1'b1);
      u_chk.end_test();

      // Loads only while few words wait so unread words never fill the data RAM
      u_chk.begin_test(5, "random stores");
      for (int k = 0; k < 20; k++)
      begin
         if (unread_q.size() < 12)
            load_words($urandom % 12);
         run_store(3'($urandom % 8), 5'($urandom % 11), 1'b1);
      end
      u_chk.end_test();

      // Five full stores leave 9 free result entries and the sixth needs 11
      u_chk.begin_test(6, "result FIFO back-pressure");
      hold_res = 1'b1;
      for (int k = 0; k < 5; k++)
      begin
         load_words(11);
         run_store(3'(k), 5'd10, 1'b1);
      end
      if (res_count != 7'd55)
         u_chk.flag_mismatch($sformatf("result FIFO holds %0d tokens, expected 55", res_count));
      load_words(11);
      fork
         run_store(3'd7, 5'd10, 1'b0);
         begin
            repeat (40) @(negedge clk);
            hold_res = 1'b0;
         end
      join
      if (last_latency <= 41)
         u_chk.flag_problem("store finished while the result FIFO had no room");
      u_chk.end_test();

      u_chk.report_totals();
      if (u_chk.error_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
